// ==== hdl/membridge_pkg.sv ====
/* Shared widths, AXI4-Lite register map and bundle types of the stream-to-memory bridge.
   Imported by every RTL module of the bridge. */
package membridge_pkg;

    localparam int WORD_ADDR_W           = 29;   // 64-bit word addresses and counts
    localparam int BYTE_ADDR_W           = 32;   // AXI byte address
    localparam int DATA_W                = 64;   // stream and W beat width
    localparam int BURST_MAX             = 16;   // beats in a full burst
    localparam int BLEN_W                = 4;    // awlen field, beats minus one
    localparam int MAX_OUTSTANDING_WORDS = 64;   // issued but not yet confirmed by B
    localparam int OUTST_W               = 8;
    localparam int BQ_DEPTH              = 4;    // burst length queues
    localparam int BQ_PTR_W              = $clog2(BQ_DEPTH);
    localparam int AXIL_ADDR_W           = 8;
    localparam int AXIL_DATA_W           = 32;

    // AXI4-Lite byte offsets
    localparam logic [AXIL_ADDR_W-1:0] REG_CTRL    = 8'h00; // bit0 enable, bit1 start, bit2 reset addr
    localparam logic [AXIL_ADDR_W-1:0] REG_STATUS  = 8'h04; // read only, bit0 busy, bit1 done
    localparam logic [AXIL_ADDR_W-1:0] REG_LO_ADDR = 8'h08; // region base in words
    localparam logic [AXIL_ADDR_W-1:0] REG_SIZE    = 8'h0C; // region size in words
    localparam logic [AXIL_ADDR_W-1:0] REG_START   = 8'h10; // start offset from base
    localparam logic [AXIL_ADDR_W-1:0] REG_LEN     = 8'h14; // transfer length in words

    typedef struct packed {
        logic [WORD_ADDR_W-1:0] lo_addr;
        logic [WORD_ADDR_W-1:0] size;
        logic [WORD_ADDR_W-1:0] start_ofs;
        logic [WORD_ADDR_W-1:0] len;
        logic                   reset_addr; // restart from start_ofs on start
    } xfer_cfg_t;

    typedef struct packed {
        logic [BYTE_ADDR_W-1:0] addr;
        logic [BLEN_W-1:0]      len;        // beats minus one
    } burst_req_t;

    typedef struct packed {
        logic [AXIL_ADDR_W-1:0]   awaddr;
        logic                     awvalid;
        logic [AXIL_DATA_W-1:0]   wdata;
        logic [AXIL_DATA_W/8-1:0] wstrb;
        logic                     wvalid;
        logic                     bready;
        logic [AXIL_ADDR_W-1:0]   araddr;
        logic                     arvalid;
        logic                     rready;
    } axil_req_t;

    typedef struct packed {
        logic                   awready;
        logic                   wready;
        logic                   bvalid;
        logic [1:0]             bresp;
        logic                   arready;
        logic                   rvalid;
        logic [AXIL_DATA_W-1:0] rdata;
        logic [1:0]             rresp;
    } axil_rsp_t;

endpackage

// ==== hdl/membridge_regs.sv ====
/* AXI4-Lite slave holding the transfer configuration, the enable and start controls
   and the busy/done status of the bridge. */
`timescale 1ns/1ps
module membridge_regs (
    input  logic                     hclk,
    input  logic                     rst,
    input  membridge_pkg::axil_req_t axil_i,
    output membridge_pkg::axil_rsp_t axil_o,
    input  logic                     busy_i,
    input  logic                     done_i,   // one-cycle pulse from the address generator
    output membridge_pkg::xfer_cfg_t cfg_o,
    output logic                     enable_o,
    output logic                     start_o   // one-cycle pulse
);
    import membridge_pkg::*;

    logic                   wr_hs;      // aw and w accepted together
    logic                   b_pend;     // write done, response goes out next cycle
    logic                   bvalid_r;
    logic                   rvalid_r;
    logic [AXIL_DATA_W-1:0] rdata_r;
    logic [AXIL_DATA_W-1:0] wr_word;    // addressed register after byte strobes
    logic                   done_r;     // sticky done for status

    function automatic logic [AXIL_DATA_W-1:0] reg_value(input logic [AXIL_ADDR_W-1:0] addr);
        logic [AXIL_DATA_W-1:0] v;
        v = '0;
        case (addr)
            REG_CTRL:    v = {29'b0, cfg_o.reset_addr, 1'b0, enable_o}; // start reads 0
            REG_STATUS:  v = {30'b0, done_r, busy_i};
            REG_LO_ADDR: v = AXIL_DATA_W'(cfg_o.lo_addr);
            REG_SIZE:    v = AXIL_DATA_W'(cfg_o.size);
            REG_START:   v = AXIL_DATA_W'(cfg_o.start_ofs);
            REG_LEN:     v = AXIL_DATA_W'(cfg_o.len);
            default:     v = '0;
        endcase
        return v;
    endfunction

    function automatic logic [AXIL_DATA_W-1:0] merge_strb(
        input logic [AXIL_DATA_W-1:0]   old_v,
        input logic [AXIL_DATA_W-1:0]   new_v,
        input logic [AXIL_DATA_W/8-1:0] strb
    );
        logic [AXIL_DATA_W-1:0] v;
        v = old_v;
        for (int i = 0; i < AXIL_DATA_W/8; i++) begin
            if (strb[i]) begin
                v[8*i +: 8] = new_v[8*i +: 8]; // byte lane taken from wdata
            end
        end
        return v;
    endfunction

    assign wr_hs   = axil_i.awvalid && axil_i.wvalid && !b_pend && !bvalid_r;
    assign wr_word = merge_strb(reg_value(axil_i.awaddr), axil_i.wdata, axil_i.wstrb);

    assign axil_o.awready = wr_hs;    // both channels accepted in the same cycle
    assign axil_o.wready  = wr_hs;
    assign axil_o.bvalid  = bvalid_r;
    assign axil_o.bresp   = 2'b00;    // always okay
    assign axil_o.arready = !rvalid_r;
    assign axil_o.rvalid  = rvalid_r;
    assign axil_o.rdata   = rdata_r;
    assign axil_o.rresp   = 2'b00;

    always_ff @(posedge hclk or posedge rst) begin
        if (rst) begin
            cfg_o    <= '0;
            enable_o <= 1'b0;
            start_o  <= 1'b0;
            b_pend   <= 1'b0;
            bvalid_r <= 1'b0;
            rvalid_r <= 1'b0;
            done_r   <= 1'b0;
        end else begin
            start_o <= 1'b0;
            if (wr_hs) begin
                case (axil_i.awaddr)
                    REG_CTRL: begin
                        enable_o         <= wr_word[0];
                        cfg_o.reset_addr <= wr_word[2];
                        start_o          <= wr_word[1] && wr_word[0]; // start needs enable
                    end
                    REG_LO_ADDR: begin
                        cfg_o.lo_addr   <= {wr_word[WORD_ADDR_W-1:4], 4'h0}; // 16-word aligned
                        cfg_o.start_ofs <= '0;                               // new base, restart at 0
                    end
                    REG_SIZE:  cfg_o.size      <= {wr_word[WORD_ADDR_W-1:4], 4'h0};
                    REG_START: cfg_o.start_ofs <= {wr_word[WORD_ADDR_W-1:4], 4'h0};
                    REG_LEN:   cfg_o.len       <= wr_word[WORD_ADDR_W-1:0]; // any length
                    default: ;
                endcase
            end

            b_pend <= wr_hs;
            if (b_pend) begin
                bvalid_r <= 1'b1;                  // 2 cycles after the handshake
            end else if (axil_i.bready) begin
                bvalid_r <= 1'b0;
            end

            if (axil_i.arvalid && !rvalid_r) begin
                rvalid_r <= 1'b1;
            end else if (axil_i.rready) begin
                rvalid_r <= 1'b0;
            end

            if (!enable_o || start_o) begin
                done_r <= 1'b0;                    // disabling or restarting clears done
            end else if (done_i) begin
                done_r <= 1'b1;
            end
        end
    end

    always_ff @(posedge hclk) begin
        if (axil_i.arvalid && !rvalid_r) begin
            rdata_r <= reg_value(axil_i.araddr);
        end
    end

endmodule

// ==== hdl/burst_addr_gen.sv ====
/* Issues AXI write bursts over a circular memory region and tracks words awaiting
   a write response, signalling busy and done for the whole transfer. */
`timescale 1ns/1ps
module burst_addr_gen (
    input  logic                      hclk,
    input  logic                      rst,
    input  membridge_pkg::xfer_cfg_t  cfg_i,
    input  logic                      enable_i,
    input  logic                      start_i,
    output membridge_pkg::burst_req_t aw_o,
    output logic                      awvalid_o,
    input  logic                      awready_i,
    input  logic                      bvalid_i,
    input  logic                      bq_full_i,   // streamer cannot take another length
    output logic                      busy_o,
    output logic                      done_o       // one-cycle pulse
);
    import membridge_pkg::*;

    logic                   active;
    logic [WORD_ADDR_W-1:0] rel_addr;   // offset from lo_addr
    logic [WORD_ADDR_W-1:0] left;       // words not yet issued
    logic                   last_r;     // issued burst is the partial tail
    logic                   roll_r;     // issued burst sits in the final block
    logic [OUTST_W-1:0]     outst;      // words waiting for B
    logic [OUTST_W-1:0]     aw_words;
    logic [OUTST_W-1:0]     b_words;
    logic [BLEN_W-1:0]      cq_mem [BQ_DEPTH]; // lengths awaiting B, oldest first
    logic [BQ_PTR_W-1:0]    cq_wr;
    logic [BQ_PTR_W-1:0]    cq_rd;
    logic                   aw_hs;
    logic                   can_issue;
    logic                   tail;       // fewer than 16 words left

    assign tail      = (left[WORD_ADDR_W-1:4] == '0);
    assign aw_hs     = awvalid_o && awready_i;
    assign aw_words  = OUTST_W'(aw_o.len) + OUTST_W'(1);
    assign b_words   = bvalid_i ? OUTST_W'(cq_mem[cq_rd]) + OUTST_W'(1) : '0;
    assign can_issue = active && enable_i && !start_i && !awvalid_o && (left != '0) &&
                       !bq_full_i &&
                       (outst <= OUTST_W'(MAX_OUTSTANDING_WORDS - BURST_MAX));

    assign busy_o = active;
    assign done_o = active && !start_i && !awvalid_o && (left == '0) && (outst == '0);

    always_ff @(posedge hclk or posedge rst) begin
        if (rst) begin
            active    <= 1'b0;
            awvalid_o <= 1'b0;
            rel_addr  <= '0;
            left      <= '0;
            last_r    <= 1'b0;
            roll_r    <= 1'b0;
            outst     <= '0;
            cq_wr     <= '0;
            cq_rd     <= '0;
        end else begin
            if (start_i) begin
                active <= 1'b1;
            end else if (done_o) begin
                active <= 1'b0;
            end

            if (start_i) begin
                left <= cfg_i.len;
                if (cfg_i.reset_addr) begin
                    rel_addr <= cfg_i.start_ofs;   // else continue from current address
                end
            end else if (aw_hs) begin
                if (last_r) begin
                    rel_addr <= rel_addr + WORD_ADDR_W'(left[3:0]);
                    left     <= '0;
                end else begin
                    rel_addr <= roll_r ? '0 : rel_addr + WORD_ADDR_W'(BURST_MAX);
                    left     <= left - WORD_ADDR_W'(BURST_MAX);
                end
            end

            if (can_issue) begin
                awvalid_o <= 1'b1;
                last_r    <= tail;
                roll_r    <= (rel_addr == cfg_i.size - WORD_ADDR_W'(BURST_MAX));
            end else if (aw_hs) begin
                awvalid_o <= 1'b0;
            end

            outst <= outst + (aw_hs ? aw_words : '0) - b_words;
            if (aw_hs) begin
                cq_wr <= cq_wr + 1'b1;
            end
            if (bvalid_i) begin
                cq_rd <= cq_rd + 1'b1;             // one B per burst, in order
            end
        end
    end

    always_ff @(posedge hclk) begin
        if (can_issue) begin
            aw_o.addr <= {cfg_i.lo_addr + rel_addr, 3'b000}; // words to bytes
            aw_o.len  <= tail ? left[3:0] - 1'b1 : BLEN_W'(BURST_MAX - 1);
        end
        if (aw_hs) begin
            cq_mem[cq_wr] <= aw_o.len;
        end
    end

endmodule

// ==== hdl/wdata_streamer.sv ====
/* Passes stream words onto the AXI W channel, one burst per queued length,
   and marks the final beat of each burst with wlast. */
`timescale 1ns/1ps
module wdata_streamer (
    input  logic                                hclk,
    input  logic                                rst,
    input  logic                                push_i,      // aw handshake
    input  logic [membridge_pkg::BLEN_W-1:0]    push_len_i,  // beats minus one
    output logic                                bq_full_o,
    input  logic [membridge_pkg::DATA_W-1:0]    word_i,
    input  logic                                word_valid_i,
    output logic                                word_ready_o,
    output logic [membridge_pkg::DATA_W-1:0]    wdata_o,
    output logic                                wvalid_o,
    input  logic                                wready_i,
    output logic                                wlast_o
);
    import membridge_pkg::*;

    logic [BLEN_W-1:0]   lq_mem [BQ_DEPTH]; // burst lengths, oldest first
    logic [BQ_PTR_W-1:0] lq_wr;
    logic [BQ_PTR_W-1:0] lq_rd;
    logic [BQ_PTR_W:0]   lq_cnt;
    logic [BLEN_W-1:0]   beat;             // beat index in current burst
    logic                queued;
    logic                beat_hs;
    logic                pop;

    assign queued       = (lq_cnt != '0);
    assign bq_full_o    = (lq_cnt == (BQ_PTR_W+1)'(BQ_DEPTH));
    assign wdata_o      = word_i;                 // no buffering
    assign wvalid_o     = queued && word_valid_i;
    assign word_ready_o = queued && wready_i;
    assign wlast_o      = queued && (beat == lq_mem[lq_rd]);
    assign beat_hs      = wvalid_o && wready_i;
    assign pop          = beat_hs && wlast_o;     // burst complete

    always_ff @(posedge hclk or posedge rst) begin
        if (rst) begin
            lq_wr  <= '0;
            lq_rd  <= '0;
            lq_cnt <= '0;
            beat   <= '0;
        end else begin
            if (push_i) begin
                lq_wr <= lq_wr + 1'b1;
            end
            if (pop) begin
                lq_rd <= lq_rd + 1'b1;
                beat  <= '0;
            end else if (beat_hs) begin
                beat <= beat + 1'b1;
            end
            lq_cnt <= lq_cnt + (BQ_PTR_W+1)'(push_i) - (BQ_PTR_W+1)'(pop);
        end
    end

    always_ff @(posedge hclk) begin
        if (push_i) begin
            lq_mem[lq_wr] <= push_len_i;
        end
    end

endmodule

// ==== hdl/membridge_top.sv ====
/* Top level of the stream-to-memory bridge. Joins the AXI4-Lite register block,
   the burst address generator and the W channel streamer. */
`timescale 1ns/1ps
module membridge_top (
    input  logic                             hclk,
    input  logic                             rst,
    input  membridge_pkg::axil_req_t         axil_i,
    output membridge_pkg::axil_rsp_t         axil_o,
    input  logic [membridge_pkg::DATA_W-1:0] word_i,
    input  logic                             word_valid_i,
    output logic                             word_ready_o,
    output membridge_pkg::burst_req_t        aw_o,
    output logic                             awvalid_o,
    input  logic                             awready_i,
    output logic [membridge_pkg::DATA_W-1:0] wdata_o,
    output logic                             wvalid_o,
    output logic                             wlast_o,
    input  logic                             wready_i,
    input  logic                             bvalid_i    // bready tied high
);
    import membridge_pkg::*;

    xfer_cfg_t cfg;
    logic      enable;
    logic      start;
    logic      busy;
    logic      done;
    logic      bq_full;
    logic      aw_push;   // burst accepted, its length goes to the streamer

    assign aw_push = awvalid_o && awready_i;

    membridge_regs u_regs (
        .hclk     (hclk),
        .rst      (rst),
        .axil_i   (axil_i),
        .axil_o   (axil_o),
        .busy_i   (busy),
        .done_i   (done),
        .cfg_o    (cfg),
        .enable_o (enable),
        .start_o  (start)
    );

    burst_addr_gen u_addr_gen (
        .hclk      (hclk),
        .rst       (rst),
        .cfg_i     (cfg),
        .enable_i  (enable),
        .start_i   (start),
        .aw_o      (aw_o),
        .awvalid_o (awvalid_o),
        .awready_i (awready_i),
        .bvalid_i  (bvalid_i),
        .bq_full_i (bq_full),
        .busy_o    (busy),
        .done_o    (done)
    );

    wdata_streamer u_streamer (
        .hclk         (hclk),
        .rst          (rst),
        .push_i       (aw_push),
        .push_len_i   (aw_o.len),
        .bq_full_o    (bq_full),
        .word_i       (word_i),
        .word_valid_i (word_valid_i),
        .word_ready_o (word_ready_o),
        .wdata_o      (wdata_o),
        .wvalid_o     (wvalid_o),
        .wready_i     (wready_i),
        .wlast_o      (wlast_o)
    );

endmodule

// ==== bench/membridge_properties.sv ====
/* Concurrent checks on the AXI write address and data channels of the bridge.
   Bound to every membridge_top instance. */
`timescale 1ns/1ps
module membridge_properties (
    input logic                      hclk,
    input logic                      rst,
    input membridge_pkg::burst_req_t aw_o,
    input logic                      awvalid_o,
    input logic                      awready_i,
    input logic                      wvalid_o,
    input logic                      wready_i,
    input logic                      wlast_o
);
    import membridge_pkg::*;

    logic [5:0] beats; // beats since the last wlast

    always_ff @(posedge hclk or posedge rst) begin
        if (rst) begin
            beats <= '0;
        end else if (wvalid_o && wready_i) begin
            beats <= wlast_o ? 6'd0 : beats + 6'd1;
        end
    end

    aw_hold: assert property (@(posedge hclk) disable iff (rst)
        awvalid_o && !awready_i |=> awvalid_o && $stable(aw_o))
        else $error("aw channel changed before awready");

    w_idle_in_reset: assert property (@(posedge hclk) rst |-> !wvalid_o)
        else $error("wvalid high during reset");

    burst_max_len: assert property (@(posedge hclk) disable iff (rst)
        wvalid_o && wready_i |-> beats < 6'(BURST_MAX))
        else $error("more than 16 beats without wlast");

endmodule

bind membridge_top membridge_properties u_props (.*);

// ==== bench/membridge_tb.sv ====
/* Directed testbench of the stream-to-memory bridge with an AXI write slave model.
   Runs register, burst, rollover, continue, stall and disable tests. */
`timescale 1ns/1ps
module membridge_tb;
    import membridge_pkg::*;

    localparam int TIMEOUT = 4000;   // cycles per wait

    logic              hclk;
    logic              rst;
    axil_req_t         axil_i;
    axil_rsp_t         axil_o;
    logic [DATA_W-1:0] word_i;
    logic              word_valid_i;
    logic              word_ready_o;
    burst_req_t        aw_o;
    logic              awvalid_o;
    logic              awready_i;
    logic [DATA_W-1:0] wdata_o;
    logic              wvalid_o;
    logic              wlast_o;
    logic              wready_i;
    logic              bvalid_i;

    int                     errors;
    int                     timeouts;
    int                     b_owed;         // bursts finished on W, B not yet sent
    bit                     stall_on;
    burst_req_t             aw_log[$];
    logic [DATA_W-1:0]      data_log[$];
    bit                     last_log[$];
    logic [WORD_ADDR_W-1:0] model_rel;      // expected relative address of the bridge
    logic [31:0]            rd;

    membridge_top DUT (.*);

    initial begin
        hclk = 1'b0;
        forever #20 hclk = ~hclk;
    end

    initial begin
        forever begin
            @(posedge hclk);
            awready_i <= stall_on ? ($urandom_range(3) != 0) : 1'b1;
            wready_i  <= stall_on ? ($urandom_range(2) != 0) : 1'b1;
            if (b_owed > 0) begin
                bvalid_i <= 1'b1;   // one response per burst
                b_owed   -= 1;
            end else begin
                bvalid_i <= 1'b0;
            end
        end
    end

    initial begin
        forever begin
            @(negedge hclk);    // handshake lands on the coming edge
            if (awvalid_o && awready_i) aw_log.push_back(aw_o);
            if (wvalid_o && wready_i) begin
                data_log.push_back(wdata_o);
                last_log.push_back(wlast_o);
                if (wlast_o) b_owed += 1;
            end
        end
    end

    task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            errors += 1;
            $display("FAILED %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic note_timeout(input string what);
        timeouts += 1;
        $display("ERROR %0t: no response while waiting for %s", $time, what);
    endtask

    task automatic axil_write(input logic [7:0] addr, input logic [31:0] data);
        int n;
        @(posedge hclk);
        axil_i.awaddr  <= addr;
        axil_i.wdata   <= data;
        axil_i.wstrb   <= 4'hf;
        axil_i.awvalid <= 1'b1;
        axil_i.wvalid  <= 1'b1;
        n = 0;
        @(negedge hclk);
        while (!axil_o.awready && n < TIMEOUT) begin
            @(negedge hclk);
            n++;
        end
        if (n >= TIMEOUT) note_timeout("register write accept");
        @(posedge hclk);
        axil_i.awvalid <= 1'b0;
        axil_i.wvalid  <= 1'b0;
        n = 0;
        @(negedge hclk);
        while (!axil_o.bvalid && n < TIMEOUT) begin
            @(negedge hclk);
            n++;
        end
        if (n >= TIMEOUT) note_timeout("register write response");
        check_eq("axil bresp", 64'(axil_o.bresp), 64'd0);
        @(posedge hclk);    // bready held high
    endtask

    task automatic axil_read(input logic [7:0] addr, output logic [31:0] data);
        int n;
        @(posedge hclk);
        axil_i.araddr  <= addr;
        axil_i.arvalid <= 1'b1;
        n = 0;
        @(negedge hclk);
        while (!axil_o.arready && n < TIMEOUT) begin
            @(negedge hclk);
            n++;
        end
        if (n >= TIMEOUT) note_timeout("register read accept");
        @(posedge hclk);
        axil_i.arvalid <= 1'b0;
        n = 0;
        @(negedge hclk);
        while (!axil_o.rvalid && n < TIMEOUT) begin
            @(negedge hclk);
            n++;
        end
        if (n >= TIMEOUT) note_timeout("register read data");
        data = axil_o.rdata;
        check_eq("axil rresp", 64'(axil_o.rresp), 64'd0);
        @(posedge hclk);
    endtask

    task automatic send_words(input int count, input logic [63:0] base);
        int n;
        for (int i = 0; i < count; i++) begin
            if (stall_on && $urandom_range(3) == 0) begin
                @(posedge hclk);
                word_valid_i <= 1'b0;   // idle gap in the stream
            end
            @(posedge hclk);
            word_i       <= base + 64'(i);
            word_valid_i <= 1'b1;
            n = 0;
            @(negedge hclk);
            while (!word_ready_o && n < TIMEOUT) begin
                @(negedge hclk);
                n++;
            end
            if (n >= TIMEOUT) note_timeout("stream word accept");
        end
        @(posedge hclk);
        word_valid_i <= 1'b0;
    endtask

    task automatic wait_done();
        logic [31:0] st;
        int          polls;
        polls = 0;
        axil_read(REG_STATUS, st);
        while (!st[1] && polls < 400) begin
            check_eq("status busy", 64'(st[0]), 64'd1);   // busy until done
            axil_read(REG_STATUS, st);
            polls++;
        end
        if (!st[1]) note_timeout("done status");
        check_eq("status at end", 64'(st), 64'h2);
    endtask

    // builds expected bursts from the region rules, runs one transfer and compares
    task automatic run_xfer(input logic [WORD_ADDR_W-1:0] lo, input logic [WORD_ADDR_W-1:0] size,
                            input logic [WORD_ADDR_W-1:0] ofs, input int len,
                            input bit reset_addr, input logic [63:0] base);
        burst_req_t exp_aw[$];
        bit         exp_last[$];
        burst_req_t b;
        int         left;
        int         blen;
        if (reset_addr) model_rel = ofs;
        left = len;
        while (left > 0) begin
            blen   = (left < BURST_MAX) ? left : BURST_MAX;
            b.addr = {lo + model_rel, 3'b000};
            b.len  = BLEN_W'(blen - 1);
            exp_aw.push_back(b);
            for (int i = 0; i < blen; i++) exp_last.push_back(i == blen - 1);
            if (blen < BURST_MAX) model_rel = model_rel + WORD_ADDR_W'(blen);
            else if (model_rel == size - WORD_ADDR_W'(BURST_MAX)) model_rel = '0;
            else model_rel = model_rel + WORD_ADDR_W'(BURST_MAX);
            left -= blen;
        end
        aw_log.delete();
        data_log.delete();
        last_log.delete();
        axil_write(REG_LO_ADDR, 32'(lo));
        axil_write(REG_SIZE, 32'(size));
        axil_write(REG_START, 32'(ofs));
        axil_write(REG_LEN, 32'(len));
        axil_write(REG_CTRL, {29'b0, reset_addr, 2'b11});   // enable and start
        fork
            send_words(len, base);
            wait_done();
        join
        check_eq("aw burst count", 64'(aw_log.size()), 64'(exp_aw.size()));
        for (int i = 0; i < aw_log.size() && i < exp_aw.size(); i++) begin
            check_eq($sformatf("aw_o.addr[%0d]", i), 64'(aw_log[i].addr), 64'(exp_aw[i].addr));
            check_eq($sformatf("aw_o.len[%0d]", i), 64'(aw_log[i].len), 64'(exp_aw[i].len));
        end
        check_eq("w beat count", 64'(data_log.size()), 64'(len));
        for (int i = 0; i < data_log.size() && i < len; i++) begin
            check_eq($sformatf("wdata_o[%0d]", i), data_log[i], base + 64'(i));
            check_eq($sformatf("wlast_o[%0d]", i), 64'(last_log[i]), 64'(exp_last[i]));
        end
    endtask

    task automatic check_registers();
        axil_write(REG_LO_ADDR, 32'h0000_1237);
        axil_write(REG_START, 32'h0000_0025);
        axil_read(REG_LO_ADDR, rd);
        check_eq("REG_LO_ADDR", 64'(rd), 64'h1230);
        axil_read(REG_START, rd);
        check_eq("REG_START", 64'(rd), 64'h20);
        axil_write(REG_LO_ADDR, 32'h0000_0400);
        axil_read(REG_START, rd);
        check_eq("REG_START after base write", 64'(rd), 64'h0);
        axil_write(REG_SIZE, 32'h0000_010f);
        axil_read(REG_SIZE, rd);
        check_eq("REG_SIZE", 64'(rd), 64'h100);
        axil_write(REG_LEN, 32'h0000_0029);
        axil_read(REG_LEN, rd);
        check_eq("REG_LEN", 64'(rd), 64'h29);
    endtask

    initial begin
        void'($urandom(32'hf338c90b));
        errors       = 0;
        timeouts     = 0;
        b_owed       = 0;
        stall_on     = 1'b0;
        model_rel    = '0;
        rst          = 1'b1;
        axil_i       = '0;
        axil_i.bready = 1'b1;
        axil_i.rready = 1'b1;
        word_i       = '0;
        word_valid_i = 1'b0;
        awready_i    = 1'b0;
        wready_i     = 1'b0;
        bvalid_i     = 1'b0;
        repeat (5) @(posedge hclk);
        rst <= 1'b0;
        @(negedge hclk);
        check_eq("awvalid_o after reset", 64'(awvalid_o), 64'd0);
        check_eq("word_ready_o after reset", 64'(word_ready_o), 64'd0);
        check_eq("axil bvalid after reset", 64'(axil_o.bvalid), 64'd0);
        axil_read(REG_STATUS, rd);
        check_eq("status after reset", 64'(rd), 64'd0);

        check_registers();
        run_xfer(29'h100, 29'd256, 29'd0, 40, 1'b1, 64'h1000_0000_0000_0000);
        run_xfer(29'h100, 29'd256, 29'd0, 20, 1'b0, 64'h2000_0000_0000_0000); // continue
        run_xfer(29'h200, 29'd48, 29'd32, 64, 1'b1, 64'h3000_0000_0000_0000); // rollover
        stall_on = 1'b1;
        run_xfer(29'h400, 29'd128, 29'd16, 100, 1'b1, 64'h4000_0000_0000_0000);
        stall_on = 1'b0;
        axil_write(REG_CTRL, 32'h0);   // disable drops done
        axil_read(REG_STATUS, rd);
        check_eq("status after disable", 64'(rd), 64'd0);

        $display("summary: %0d value errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== membridge.f ====
hdl/membridge_pkg.sv
hdl/membridge_regs.sv
hdl/burst_addr_gen.sv
hdl/wdata_streamer.sv
hdl/membridge_top.sv
bench/membridge_properties.sv
bench/membridge_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the bridge testbench, pass only if the log holds the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f membridge.f \
    --top-module membridge_tb -Mdir obj_dir > build.log 2>&1 \
    && ./obj_dir/Vmembridge_tb > sim.log 2>&1
cat sim.log
grep -q "^RESULT: PASS$" sim.log && exit 0 || { echo "simulation did not pass"; exit 1; }
